// ==== rtl/cmd_if.sv ====
`timescale 1ns/100ps

// matched request, handed from frame matcher to responder
interface cmd_if import coms_pkg::*; ();

	logic cmd_valid;
	logic cmd_ready;
	frame_kind_e cmd_kind;
	logic crc_ok;

	modport matcher (output cmd_valid, output cmd_kind, output crc_ok, input cmd_ready);

	modport responder (input cmd_valid, input cmd_kind, input crc_ok, output cmd_ready);

endinterface

// ==== rtl/coms_cfg.svh ====
`ifndef COMS_CFG_SVH
`define COMS_CFG_SVH

//////////////////////////////////////////////////////////////////////
// serial line timing
//////////////////////////////////////////////////////////////////////

// clock cycles per serial bit
`define CLKS_PER_BIT 16

//////////////////////////////////////////////////////////////////////
// frame layout
//////////////////////////////////////////////////////////////////////

`define STATUS_REQUEST_MAGIC 32'hDABBAD00
`define STATUS_REQUEST_LENGTH 7
`define SETPOINT_MAGIC 32'hB16B00B5
`define SETPOINT_LENGTH 11
`define STATUS_MAGIC 32'h1CEB00DA
`define STATUS_LENGTH 21

// longest request that has to fit in the receive window
`define RX_WINDOW_LENGTH 11

// single byte replies
`define ACK_BYTE 8'hFF
`define NACK_BYTE 8'h00

// crc-16, x^16+x^15+x^2+1, msb first, no final inversion
`define CRC_INIT 16'hFFFF
`define CRC_POLY 16'h8005

`endif

// ==== rtl/coms_pkg.sv ====
package coms_pkg;

	// kind of request that the matcher recognised
	typedef enum logic {
		KIND_STATUS_REQUEST,
		KIND_SETPOINT
	} frame_kind_e;

	typedef enum logic [1:0] {
		M_IDLE,
		M_CHECK,
		M_COMPARE,
		M_HOLD
	} matcher_state_e;

	// payload, then the two crc bytes, or one ack/nack byte
	typedef enum logic [2:0] {
		R_IDLE,
		R_PAYLOAD,
		R_CRC_HI,
		R_CRC_LO,
		R_SINGLE
	} responder_state_e;

endpackage

// ==== rtl/coms_responder.sv ====
`timescale 1ns/100ps

module coms_responder import uart_pkg::*; (
	input logic CLK,
	input logic reset,
	input logic rx_i,
	input byte_t id,
	input logic signed [31:0] position,
	input logic signed [31:0] velocity,
	input logic signed [31:0] displacement,
	input logic [15:0] current,
	output logic tx_o,
	output logic tx_enable
);

	logic rx_valid;
	byte_t rx_byte;
	logic tx_valid;
	logic tx_ready;
	byte_t tx_byte;

	cmd_if cmd_bus ();

	uart_rx u_rx (
		.CLK(CLK),
		.reset(reset),
		.rx_i(rx_i),
		.rx_valid(rx_valid),
		.rx_byte(rx_byte)
	);

	frame_matcher u_matcher (
		.CLK(CLK),
		.reset(reset),
		.rx_valid(rx_valid),
		.rx_byte(rx_byte),
		.cmd(cmd_bus.matcher)
	);

	status_responder u_responder (
		.CLK(CLK),
		.reset(reset),
		.id(id),
		.position(position),
		.velocity(velocity),
		.displacement(displacement),
		.current(current),
		.tx_ready(tx_ready),
		.tx_valid(tx_valid),
		.tx_byte(tx_byte),
		.cmd(cmd_bus.responder)
	);

	// line driver enable follows the character on the wire
	uart_tx u_tx (
		.CLK(CLK),
		.reset(reset),
		.tx_valid(tx_valid),
		.tx_byte(tx_byte),
		.tx_ready(tx_ready),
		.tx_o(tx_o),
		.tx_enable(tx_enable)
	);

endmodule

// ==== rtl/crc16_engine.sv ====
`timescale 1ns/100ps
`include "coms_cfg.svh"

module crc16_engine import uart_pkg::*; (
	input logic CLK,
	input logic reset,
	input logic crc_init,
	input logic crc_step,
	input byte_t crc_byte,
	output logic [15:0] crc
);

	// eight serial steps unrolled into one cycle, msb first
	function automatic logic [15:0] fold_byte(input logic [15:0] c, input byte_t d);
		logic [15:0] r;
		logic fb;
		r = c;
		for (int i = 7; i >= 0; i--) begin
			fb = r[15] ^ d[i];
			r = {r[14:0], 1'b0};
			if (fb) r = r ^ `CRC_POLY;
		end
		return r;
	endfunction

	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			crc <= `CRC_INIT;
		end else if (crc_init) begin
			crc <= `CRC_INIT;
		end else if (crc_step) begin
			crc <= fold_byte(crc, crc_byte);
		end
	end

endmodule

// ==== rtl/frame_matcher.sv ====
`timescale 1ns/100ps
`include "coms_cfg.svh"

module frame_matcher import uart_pkg::*, coms_pkg::*; (
	input logic CLK,
	input logic reset,
	input logic rx_valid,
	input byte_t rx_byte,
	cmd_if.matcher cmd
);

	localparam int IDX_W = $clog2(`RX_WINDOW_LENGTH);

	// win[0] is the newest byte
	byte_t win [`RX_WINDOW_LENGTH];
	matcher_state_e state;
	logic new_byte;
	logic [IDX_W-1:0] idx;
	logic status_hit;
	logic setpoint_hit;
	logic issue;
	logic crc_init;
	logic crc_step;
	byte_t crc_byte;
	logic [15:0] crc;

	// magic sits in the oldest four bytes of a frame
	assign status_hit = {win[`STATUS_REQUEST_LENGTH-1], win[`STATUS_REQUEST_LENGTH-2],
		win[`STATUS_REQUEST_LENGTH-3], win[`STATUS_REQUEST_LENGTH-4]} == `STATUS_REQUEST_MAGIC;
	assign setpoint_hit = {win[`SETPOINT_LENGTH-1], win[`SETPOINT_LENGTH-2],
		win[`SETPOINT_LENGTH-3], win[`SETPOINT_LENGTH-4]} == `SETPOINT_MAGIC;

	assign issue = cmd.cmd_valid && cmd.cmd_ready;

	//////////////////////////////////////////////////////////////////////
	// receive window
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `RX_WINDOW_LENGTH; i++) win[i] <= '0;
			new_byte <= 1'b0;
		end else begin
			new_byte <= rx_valid;
			// cleared on issue so the same frame is answered once
			if (issue) begin
				for (int i = 0; i < `RX_WINDOW_LENGTH; i++) win[i] <= '0;
			end else if (rx_valid) begin
				win[0] <= rx_byte;
				for (int i = 1; i < `RX_WINDOW_LENGTH; i++) win[i] <= win[i-1];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// match, crc check and command issue
	//////////////////////////////////////////////////////////////////////

	assign crc_init = (state == M_IDLE);
	assign crc_step = (state == M_CHECK);
	assign crc_byte = win[idx];

	crc16_engine u_crc (
		.CLK(CLK),
		.reset(reset),
		.crc_init(crc_init),
		.crc_step(crc_step),
		.crc_byte(crc_byte),
		.crc(crc)
	);

	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			state <= M_IDLE;
			idx <= '0;
			cmd.cmd_valid <= 1'b0;
			cmd.cmd_kind <= KIND_STATUS_REQUEST;
			cmd.crc_ok <= 1'b0;
		end else begin
			case (state)
				M_IDLE: begin
					if (new_byte && status_hit) begin
						cmd.cmd_kind <= KIND_STATUS_REQUEST;
						idx <= IDX_W'(`STATUS_REQUEST_LENGTH - 1);
						state <= M_CHECK;
					end else if (new_byte && setpoint_hit) begin
						cmd.cmd_kind <= KIND_SETPOINT;
						idx <= IDX_W'(`SETPOINT_LENGTH - 1);
						state <= M_CHECK;
					end
				end
				M_CHECK: begin
					// oldest byte first, stop before the two crc bytes
					if (idx == IDX_W'(2)) state <= M_COMPARE;
					else idx <= idx - 1'b1;
				end
				M_COMPARE: begin
					cmd.crc_ok <= (crc == {win[1], win[0]});
					cmd.cmd_valid <= 1'b1;
					state <= M_HOLD;
				end
				M_HOLD: begin
					if (cmd.cmd_ready) begin
						cmd.cmd_valid <= 1'b0;
						state <= M_IDLE;
					end
				end
				default: state <= M_IDLE;
			endcase
		end
	end

	a_cmd_held: assert property (@(posedge CLK) disable iff (reset)
		cmd.cmd_valid && !cmd.cmd_ready |=>
		cmd.cmd_valid && $stable(cmd.cmd_kind) && $stable(cmd.crc_ok));

endmodule

// ==== rtl/status_responder.sv ====
`timescale 1ns/100ps
`include "coms_cfg.svh"

module status_responder import uart_pkg::*, coms_pkg::*; (
	input logic CLK,
	input logic reset,
	input byte_t id,
	input logic signed [31:0] position,
	input logic signed [31:0] velocity,
	input logic signed [31:0] displacement,
	input logic [15:0] current,
	input logic tx_ready,
	output logic tx_valid,
	output byte_t tx_byte,
	cmd_if.responder cmd
);

	// status frame minus its two crc bytes
	localparam int PAYLOAD_LEN = `STATUS_LENGTH - 2;
	localparam logic [4:0] LAST_IDX = 5'(PAYLOAD_LEN - 1);

	responder_state_e state;
	logic [4:0] idx;
	logic [PAYLOAD_LEN*8-1:0] payload;
	byte_t single_byte;
	logic accept;
	logic crc_init;
	logic crc_step;
	logic [15:0] crc;

	assign cmd.cmd_ready = (state == R_IDLE);
	assign tx_valid = (state != R_IDLE);
	assign accept = tx_valid && tx_ready;

	always_comb begin
		case (state)
			R_PAYLOAD: tx_byte = payload[8*(PAYLOAD_LEN-1-int'(idx)) +: 8];
			R_CRC_HI: tx_byte = crc[15:8];
			R_CRC_LO: tx_byte = crc[7:0];
			default: tx_byte = single_byte;
		endcase
	end

	// running crc over the payload bytes as the transmitter takes them
	assign crc_init = (state == R_IDLE);
	assign crc_step = accept && (state == R_PAYLOAD);

	crc16_engine u_crc (
		.CLK(CLK),
		.reset(reset),
		.crc_init(crc_init),
		.crc_step(crc_step),
		.crc_byte(tx_byte),
		.crc(crc)
	);

	// telemetry is frozen at the moment the command is taken
	always_ff @(posedge CLK) begin
		if (state == R_IDLE && cmd.cmd_valid) begin
			payload <= {`STATUS_MAGIC, id, position, velocity, displacement, current};
			single_byte <= (cmd.cmd_kind == KIND_SETPOINT && cmd.crc_ok) ? `ACK_BYTE : `NACK_BYTE;
		end
	end

	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			state <= R_IDLE;
			idx <= '0;
		end else begin
			case (state)
				R_IDLE: begin
					if (cmd.cmd_valid) begin
						idx <= '0;
						if (cmd.cmd_kind == KIND_STATUS_REQUEST && cmd.crc_ok) state <= R_PAYLOAD;
						else state <= R_SINGLE;
					end
				end
				R_PAYLOAD: begin
					if (accept) begin
						if (idx == LAST_IDX) state <= R_CRC_HI;
						else idx <= idx + 1'b1;
					end
				end
				R_CRC_HI: if (accept) state <= R_CRC_LO;
				R_CRC_LO: if (accept) state <= R_IDLE;
				R_SINGLE: if (accept) state <= R_IDLE;
				default: state <= R_IDLE;
			endcase
		end
	end

	a_payload_idx: assert property (@(posedge CLK) disable iff (reset)
		(state == R_PAYLOAD) |-> (idx < 5'(`STATUS_LENGTH - 2)));

endmodule

// ==== rtl/uart_pkg.sv ====
package uart_pkg;

	typedef logic [7:0] byte_t;

	// shared by receiver and transmitter
	typedef enum logic [1:0] {
		UART_IDLE,
		UART_START,
		UART_DATA,
		UART_STOP
	} uart_state_e;

endpackage

// ==== rtl/uart_rx.sv ====
`timescale 1ns/100ps
`include "coms_cfg.svh"

module uart_rx import uart_pkg::*; (
	input logic CLK,
	input logic reset,
	input logic rx_i,
	output logic rx_valid,
	output byte_t rx_byte
);

	localparam int CNT_W = $clog2(`CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] CNT_MID = CNT_W'(`CLKS_PER_BIT / 2 - 1);

	uart_state_e state;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic [CNT_W-1:0] cnt;
	logic [2:0] bit_idx;

	// two flop synchronizer plus one more for edge detection
	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx_i;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			state <= UART_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				UART_IDLE: begin
					cnt <= '0;
					if (rx_prev && !rx_sync) state <= UART_START;
				end
				UART_START: begin
					// a glitch that is high again at mid start bit is dropped
					if (cnt == CNT_MID) begin
						cnt <= '0;
						bit_idx <= '0;
						state <= rx_sync ? UART_IDLE : UART_DATA;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				UART_DATA: begin
					if (cnt == CNT_LAST) begin
						cnt <= '0;
						if (bit_idx == 3'd7) state <= UART_STOP;
						else bit_idx <= bit_idx + 1'b1;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				UART_STOP: begin
					if (cnt == CNT_LAST) begin
						rx_valid <= 1'b1;
						state <= UART_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= UART_IDLE;
			endcase
		end
	end

	// lsb arrives first, so shift in from the top
	always_ff @(posedge CLK) begin
		if (state == UART_DATA && cnt == CNT_LAST) rx_byte <= {rx_sync, rx_byte[7:1]};
	end

endmodule

// ==== rtl/uart_tx.sv ====
`timescale 1ns/100ps
`include "coms_cfg.svh"

module uart_tx import uart_pkg::*; (
	input logic CLK,
	input logic reset,
	input logic tx_valid,
	input byte_t tx_byte,
	output logic tx_ready,
	output logic tx_o,
	output logic tx_enable
);

	localparam int CNT_W = $clog2(`CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CLKS_PER_BIT - 1);

	uart_state_e state;
	logic [CNT_W-1:0] cnt;
	logic [2:0] bit_idx;
	byte_t shreg;

	assign tx_ready = (state == UART_IDLE);

	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			state <= UART_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			tx_o <= 1'b1;
			tx_enable <= 1'b0;
		end else begin
			case (state)
				UART_IDLE: begin
					cnt <= '0;
					if (tx_valid) begin
						// start bit goes on the line from the next cycle
						tx_o <= 1'b0;
						tx_enable <= 1'b1;
						state <= UART_START;
					end
				end
				UART_START: begin
					if (cnt == CNT_LAST) begin
						cnt <= '0;
						bit_idx <= '0;
						tx_o <= shreg[0];
						state <= UART_DATA;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				UART_DATA: begin
					if (cnt == CNT_LAST) begin
						cnt <= '0;
						if (bit_idx == 3'd7) begin
							tx_o <= 1'b1;
							state <= UART_STOP;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							tx_o <= shreg[1];
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				UART_STOP: begin
					// driver released only after the full stop bit
					if (cnt == CNT_LAST) begin
						tx_enable <= 1'b0;
						state <= UART_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= UART_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == UART_IDLE && tx_valid) shreg <= tx_byte;
		else if (state == UART_DATA && cnt == CNT_LAST) shreg <= shreg >> 1;
	end

	a_enable_off_in_idle: assert property (@(posedge CLK) disable iff (reset)
		(state == UART_IDLE) |-> !tx_enable);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the coms_responder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_coms_responder \
	-f verilog.f -o sim_coms_responder

# the log decides the result, not the simulator exit code
./obj_dir/sim_coms_responder > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASSED$" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

// ==== verification/tb_coms_responder.sv ====
`timescale 1ns/100ps
`include "coms_cfg.svh"

module tb_coms_responder;

	localparam int TIMEOUT_CYCLES = 40000;
	localparam int START_WAIT = 400;
	localparam int CHAR_CYCLES = 10 * `CLKS_PER_BIT;

	logic CLK = 1'b0;
	logic reset;
	logic rx_i;
	logic [7:0] id;
	logic signed [31:0] position;
	logic signed [31:0] velocity;
	logic signed [31:0] displacement;
	logic [15:0] current;
	logic tx_o;
	logic tx_enable;

	// request bytes to send, reply bytes seen on tx_o, expected reply
	logic [7:0] req_buf [0:31];
	logic [7:0] rsp_buf [0:31];
	logic [7:0] exp_buf [0:31];
	int error_count = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int cycle_count = 0;

	coms_responder DUT (
		.CLK(CLK),
		.reset(reset),
		.rx_i(rx_i),
		.id(id),
		.position(position),
		.velocity(velocity),
		.displacement(displacement),
		.current(current),
		.tx_o(tx_o),
		.tx_enable(tx_enable)
	);

	always #4 CLK = ~CLK;

	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the DUT stopped answering", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// reporting and reference model
	//////////////////////////////////////////////////////////////////////

	task automatic report_failure(input string what);
		$display("ERROR at %0t: %s", $time, what);
		error_count++;
	endtask

	task automatic report_mismatch(input string name, input logic [7:0] exp, input logic [7:0] got);
		$display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, got);
		error_count++;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			tests_passed++;
			$display("%s: pass", name);
		end else begin
			tests_failed++;
			$display("%s: fail with %0d errors", name, error_count - errors_before);
		end
	endtask

	// bit serial, msb first, poly 8005, no final inversion
	function automatic logic [15:0] crc16_ref(input logic [7:0] data [0:31], input int len);
		logic [15:0] c;
		logic fb;
		c = `CRC_INIT;
		for (int i = 0; i < len; i++) begin
			for (int k = 7; k >= 0; k--) begin
				fb = c[15] ^ data[i][k];
				c = fb ? ((c << 1) ^ `CRC_POLY) : (c << 1);
			end
		end
		return c;
	endfunction

	function automatic string field_name(input int i);
		if (i < 4) return $sformatf("magic[%0d]", i);
		else if (i == 4) return "id";
		else if (i < 9) return $sformatf("position[%0d]", i - 5);
		else if (i < 13) return $sformatf("velocity[%0d]", i - 9);
		else if (i < 17) return $sformatf("displacement[%0d]", i - 13);
		else if (i < 19) return $sformatf("current[%0d]", i - 17);
		else if (i == 19) return "crc_hi";
		else return "crc_lo";
	endfunction

	//////////////////////////////////////////////////////////////////////
	// serial driver and monitor
	//////////////////////////////////////////////////////////////////////

	task automatic send_byte(input logic [7:0] b);
		rx_i <= 1'b0;
		repeat (`CLKS_PER_BIT) @(posedge CLK);
		for (int i = 0; i < 8; i++) begin
			rx_i <= b[i];
			repeat (`CLKS_PER_BIT) @(posedge CLK);
		end
		rx_i <= 1'b1;
		repeat (`CLKS_PER_BIT) @(posedge CLK);
	endtask

	task automatic send_frame(input int len);
		@(posedge CLK);
		for (int i = 0; i < len; i++) send_byte(req_buf[i]);
	endtask

	task automatic recv_byte(output logic [7:0] b, output logic ok, input int max_wait);
		int waited;
		b = 8'h00;
		ok = 1'b0;
		waited = 0;
		@(posedge CLK);
		while (tx_o !== 1'b0 && waited < max_wait) begin
			@(posedge CLK);
			waited++;
		end
		if (tx_o !== 1'b0) begin
			report_failure($sformatf("no start bit on tx_o within %0d cycles", max_wait));
			return;
		end
		repeat (`CLKS_PER_BIT / 2) @(posedge CLK);
		if (tx_o !== 1'b0) report_failure("start bit on tx_o is not low at its middle");
		if (tx_enable !== 1'b1) report_failure("tx_enable is low during the start bit");
		for (int i = 0; i < 8; i++) begin
			repeat (`CLKS_PER_BIT) @(posedge CLK);
			b[i] = tx_o;
			if (tx_enable !== 1'b1) report_failure("tx_enable is low during a character");
		end
		repeat (`CLKS_PER_BIT) @(posedge CLK);
		if (tx_o !== 1'b1) report_failure("stop bit on tx_o is low");
		if (tx_enable !== 1'b1) report_failure("tx_enable is low during the stop bit");
		ok = 1'b1;
	endtask

	task automatic recv_frame(input int n, input int first_wait, output int got);
		logic [7:0] b;
		logic ok;
		got = 0;
		for (int i = 0; i < n; i++) begin
			recv_byte(b, ok, (i == 0) ? first_wait : START_WAIT);
			if (!ok) return;
			rsp_buf[i] = b;
			got++;
		end
	endtask

	task automatic expect_quiet(input int n, input logic check_en);
		for (int i = 0; i < n; i++) begin
			@(posedge CLK);
			if (tx_o !== 1'b1) begin
				report_failure("unexpected start bit on tx_o");
				return;
			end
			if (check_en && tx_enable !== 1'b0) begin
				report_failure("tx_enable is high with nothing to send");
				return;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// frame builders and checks
	//////////////////////////////////////////////////////////////////////

	task automatic build_status_request(input logic [7:0] req_id, input logic bad_crc);
		logic [31:0] m;
		logic [15:0] c;
		m = `STATUS_REQUEST_MAGIC;
		for (int i = 0; i < 4; i++) req_buf[i] = m[8*(3-i) +: 8];
		req_buf[4] = req_id;
		c = crc16_ref(req_buf, 5);
		if (bad_crc) c[5] = ~c[5];
		req_buf[5] = c[15:8];
		req_buf[6] = c[7:0];
	endtask

	task automatic build_setpoint(input logic [7:0] req_id);
		logic [31:0] m;
		logic [31:0] sp;
		logic [15:0] c;
		m = `SETPOINT_MAGIC;
		sp = $urandom;
		for (int i = 0; i < 4; i++) req_buf[i] = m[8*(3-i) +: 8];
		req_buf[4] = req_id;
		for (int i = 0; i < 4; i++) req_buf[5+i] = sp[8*(3-i) +: 8];
		c = crc16_ref(req_buf, 9);
		req_buf[9] = c[15:8];
		req_buf[10] = c[7:0];
	endtask

	task automatic randomize_telemetry();
		@(posedge CLK);
		id <= 8'($urandom);
		position <= $urandom;
		velocity <= $urandom;
		displacement <= $urandom;
		current <= 16'($urandom);
		@(posedge CLK);
	endtask

	task automatic check_status_frame(input logic [7:0] e_id, input logic [31:0] e_pos,
		input logic [31:0] e_vel, input logic [31:0] e_disp, input logic [15:0] e_cur);
		logic [31:0] m;
		logic [15:0] c;
		m = `STATUS_MAGIC;
		// every field goes out big-endian
		for (int i = 0; i < 4; i++) begin
			exp_buf[i] = m[8*(3-i) +: 8];
			exp_buf[5+i] = e_pos[8*(3-i) +: 8];
			exp_buf[9+i] = e_vel[8*(3-i) +: 8];
			exp_buf[13+i] = e_disp[8*(3-i) +: 8];
		end
		exp_buf[4] = e_id;
		exp_buf[17] = e_cur[15:8];
		exp_buf[18] = e_cur[7:0];
		c = crc16_ref(exp_buf, 19);
		exp_buf[19] = c[15:8];
		exp_buf[20] = c[7:0];
		for (int i = 0; i < `STATUS_LENGTH; i++) begin
			if (rsp_buf[i] !== exp_buf[i]) report_mismatch(field_name(i), exp_buf[i], rsp_buf[i]);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_idle_line();
		int e;
		e = error_count;
		expect_quiet(200, 1'b1);
		finish_test("idle_line", e);
	endtask

	task automatic test_status_request();
		int e;
		int got;
		e = error_count;
		randomize_telemetry();
		build_status_request(8'h3C, 1'b0);
		fork
			send_frame(`STATUS_REQUEST_LENGTH);
			recv_frame(`STATUS_LENGTH, `STATUS_REQUEST_LENGTH * CHAR_CYCLES + 200, got);
		join
		if (got != `STATUS_LENGTH)
			report_failure($sformatf("status frame has %0d of %0d bytes", got, `STATUS_LENGTH));
		else
			check_status_frame(id, position, velocity, displacement, current);
		expect_quiet(200, 1'b0);
		finish_test("status_request", e);
	endtask

	// reply is a single byte, then the line stays idle
	task automatic test_single_reply(input string name, input int len, input logic [7:0] exp);
		int e;
		int got;
		e = error_count;
		fork
			send_frame(len);
			recv_frame(1, len * CHAR_CYCLES + 200, got);
		join
		if (got != 1) report_failure("no reply byte on tx_o");
		else if (rsp_buf[0] !== exp) report_mismatch("reply", exp, rsp_buf[0]);
		expect_quiet(400, 1'b0);
		finish_test(name, e);
	endtask

	task automatic test_noise();
		int e;
		logic [7:0] b;
		e = error_count;
		// no DA or B1 means neither magic number can form
		for (int i = 0; i < 16; i++) begin
			b = 8'($urandom);
			if (b == 8'hDA || b == 8'hB1) b = b ^ 8'h01;
			req_buf[i] = b;
		end
		send_frame(16);
		expect_quiet(500, 1'b1);
		finish_test("noise", e);
	endtask

	task automatic test_back_to_back();
		int e;
		int got1;
		int got2;
		int waited;
		logic [7:0] id1;
		logic [31:0] pos1;
		logic [31:0] vel1;
		logic [31:0] disp1;
		logic [15:0] cur1;
		e = error_count;
		randomize_telemetry();
		id1 = id;
		pos1 = position;
		vel1 = velocity;
		disp1 = displacement;
		cur1 = current;
		build_status_request(8'h5A, 1'b0);
		fork
			begin
				send_frame(`STATUS_REQUEST_LENGTH);
				send_frame(`STATUS_REQUEST_LENGTH);
			end
			begin
				// new telemetry once the first frame has been snapshotted
				waited = 0;
				while (tx_enable !== 1'b1 && waited < 2000) begin
					@(posedge CLK);
					waited++;
				end
				if (tx_enable !== 1'b1) report_failure("first status frame never started");
				randomize_telemetry();
			end
			begin
				recv_frame(`STATUS_LENGTH, `STATUS_REQUEST_LENGTH * CHAR_CYCLES + 200, got1);
				if (got1 != `STATUS_LENGTH) report_failure("first status frame is short");
				else check_status_frame(id1, pos1, vel1, disp1, cur1);
				recv_frame(`STATUS_LENGTH, START_WAIT + CHAR_CYCLES, got2);
				if (got2 != `STATUS_LENGTH) report_failure("second status frame is short");
				else check_status_frame(id, position, velocity, displacement, current);
			end
		join
		expect_quiet(200, 1'b0);
		finish_test("back_to_back", e);
	endtask

	initial begin
		reset <= 1'b1;
		rx_i <= 1'b1;
		id <= 8'h00;
		position <= '0;
		velocity <= '0;
		displacement <= '0;
		current <= 16'h0000;
		void'($urandom(32'h21c6));
		repeat (8) @(posedge CLK);
		reset <= 1'b0;
		@(posedge CLK);

		test_idle_line();
		test_status_request();
		build_setpoint(8'h11);
		test_single_reply("setpoint_ack", `SETPOINT_LENGTH, `ACK_BYTE);
		build_status_request(8'h22, 1'b1);
		test_single_reply("bad_crc_nack", `STATUS_REQUEST_LENGTH, `NACK_BYTE);
		test_noise();
		test_back_to_back();

		$display("summary: %0d passed, %0d failed, %0d errors",
			tests_passed, tests_failed, error_count);
		if (tests_failed == 0 && error_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/uart_pkg.sv
rtl/coms_pkg.sv
rtl/cmd_if.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/crc16_engine.sv
rtl/frame_matcher.sv
rtl/status_responder.sv
rtl/coms_responder.sv
verification/tb_coms_responder.sv
